/* cam_frame_ctrl.sv */
`timescale 1ns/1ps

module cam_frame_ctrl (
    input  logic video_clk,
    input  logic rst_n,
    input  logic vsync,    // camera frame blanking
    output logic grab,     // frame in progress
    output logic publish   // one-cycle latch strobe
);

    typedef enum logic [1:0] {
        st_wait_frame,
        st_grab,
        st_publish
    } frame_state_t;

    frame_state_t state;
    frame_state_t state_nxt;
    logic         vsync_d;      // previous vsync for edge detect
    logic         vsync_fall;
    logic         vsync_rise;

    assign vsync_fall = vsync_d & ~vsync;
    assign vsync_rise = ~vsync_d & vsync;

    always_comb begin
        state_nxt = state;
        case (state)
            st_wait_frame: if (vsync_fall) state_nxt = st_grab;   // frame starts
            st_grab:       if (vsync_rise) state_nxt = st_publish; // frame done
            st_publish:    state_nxt = st_wait_frame;              // single cycle
            default:       state_nxt = st_wait_frame;
        endcase
    end

    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_wait_frame;
            vsync_d <= 1'b0;
        end else begin
            state   <= state_nxt;
            vsync_d <= vsync;
        end
    end

    assign grab    = (state == st_grab);     // level while capturing
    assign publish = (state == st_publish);  // pulse, copy grid out

endmodule

/* cam_pkg.sv */
package cam_pkg;

    // ------------------------------------------------------------------------
    // grid and classifier geometry
    // ------------------------------------------------------------------------
    localparam int GRID_SIZE     = 28;  // cells per side of sampled image
    localparam int NUM_CLASSES   = 10;  // digit classes 0..9
    localparam int BIN_THRESHOLD = 30;  // r+g+b below this -> ink

    // ------------------------------------------------------------------------
    // camera pixel stream
    // ------------------------------------------------------------------------
    typedef logic [15:0] rgb565_t;  // r[15:11] g[10:5] b[4:0]

    typedef struct packed {
        logic    vsync;  // frame blanking, high between frames
        logic    href;   // line active
        logic    valid;  // pixel strobe
        rgb565_t pixel;
    } cam_in_t;

    // bit row*GRID_SIZE+col holds cell (row, col)
    typedef logic [GRID_SIZE*GRID_SIZE-1:0] bin_img_t;

    // one bit per class indicator cell
    typedef logic [NUM_CLASSES-1:0] class_vec_t;

endpackage

/* cam_sampler.sv */
`timescale 1ns/1ps

module cam_sampler import cam_pkg::*; #(
    parameter int SAMPLE_SHIFT = 3   // decimation step is 2**SAMPLE_SHIFT
) (
    input  logic     video_clk,
    input  logic     rst_n,
    input  cam_in_t  cam,
    input  logic     grab,
    input  logic     publish,
    output bin_img_t bin_img
);

    localparam int STEP = 1 << SAMPLE_SHIFT;

    typedef logic [11:0] cam_cnt_t;  // camera line/column count
    typedef logic [7:0]  luma_t;     // crude r+g+b brightness

    cam_cnt_t col_cnt;
    cam_cnt_t row_cnt;
    cam_cnt_t col_cell;      // column in cells
    cam_cnt_t row_cell;      // row in cells
    logic     href_d;
    logic     on_grid;
    logic     take;          // sample this pixel
    luma_t    luma;
    logic     ink;           // dark pixel -> 1
    bin_img_t shr;           // sample shift register

    // ------------------------------------------------------------------------
    // camera position
    // ------------------------------------------------------------------------
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
            href_d  <= 1'b0;
        end else begin
            href_d <= cam.href;
            if (!cam.href) begin
                col_cnt <= '0;                    // line blanking
            end else if (cam.valid) begin
                col_cnt <= col_cnt + 1'b1;        // one per pixel
            end
            if (!grab) begin
                row_cnt <= '0;                    // between frames
            end else if (href_d && !cam.href) begin
                row_cnt <= row_cnt + 1'b1;        // end of line
            end
        end
    end

    // ------------------------------------------------------------------------
    // decimation and threshold
    // ------------------------------------------------------------------------
    assign col_cell = col_cnt >> SAMPLE_SHIFT;
    assign row_cell = row_cnt >> SAMPLE_SHIFT;
    assign on_grid  = ((col_cnt & cam_cnt_t'(STEP - 1)) == '0)
                   && ((row_cnt & cam_cnt_t'(STEP - 1)) == '0)
                   && (col_cell < GRID_SIZE) && (row_cell < GRID_SIZE);
    assign take     = cam.href && cam.valid && on_grid;

    assign luma = luma_t'(cam.pixel[15:11]) + luma_t'(cam.pixel[10:5])
                + luma_t'(cam.pixel[4:0]);       // 5+6+5 bit fields
    assign ink  = (luma < BIN_THRESHOLD);

    // newest sample enters at the top, first one lands in bit 0
    always_ff @(posedge video_clk) begin
        if (take) begin
            shr <= {ink, shr[$bits(bin_img_t)-1:1]};
        end
    end

    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            bin_img <= '0;
        end else if (publish) begin
            bin_img <= shr;                       // whole frame at once
        end
    end

endmodule

/* mnist_view_top.sv */
`timescale 1ns/1ps

module mnist_view_top import cam_pkg::*, video_pkg::*; #(
    parameter int H_ACTIVE     = 1280,
    parameter int H_FRONT      = 110,
    parameter int H_SYNC       = 40,
    parameter int H_BACK       = 220,
    parameter int V_ACTIVE     = 720,
    parameter int V_FRONT      = 5,
    parameter int V_SYNC       = 5,
    parameter int V_BACK       = 20,
    parameter int SAMPLE_SHIFT = 3,
    parameter int BIN_SHIFT    = 4,
    parameter int BIN_X        = 50,
    parameter int BIN_Y        = 1,
    parameter int CLASS_SHIFT  = 5,
    parameter int CLASS_X      = 1,
    parameter int CLASS_Y      = 18
) (
    input  logic       video_clk,
    input  logic       rst_n,
    input  cam_in_t    cam,
    input  class_vec_t class_vec,
    output vid_sync_t  sync_out,
    output rgb888_t    pixel_out
);

    vid_pos_t timing;     // raster position, 1 cycle behind counters
    logic     grab;
    logic     publish;
    bin_img_t bin_img;    // last complete camera grid

    video_timing #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) u_timing (.video_clk, .rst_n, .timing);

    cam_frame_ctrl u_frame_ctrl (.video_clk, .rst_n, .vsync(cam.vsync), .grab, .publish);

    cam_sampler #(.SAMPLE_SHIFT(SAMPLE_SHIFT)) u_sampler (
        .video_clk, .rst_n, .cam, .grab, .publish, .bin_img
    );

    overlay_mixer #(
        .BIN_SHIFT   (BIN_SHIFT),   .BIN_X   (BIN_X),   .BIN_Y   (BIN_Y),
        .CLASS_SHIFT (CLASS_SHIFT), .CLASS_X (CLASS_X), .CLASS_Y (CLASS_Y)
    ) u_mixer (.video_clk, .rst_n, .timing, .bin_img, .class_vec, .sync_out, .pixel_out);

endmodule

/* overlay_mixer.sv */
`timescale 1ns/1ps

module overlay_mixer import cam_pkg::*, video_pkg::*; #(
    parameter int BIN_SHIFT   = 4,   // log2 of binary cell size
    parameter int BIN_X       = 50,  // window origin in cells
    parameter int BIN_Y       = 1,
    parameter int CLASS_SHIFT = 5,   // log2 of class cell size
    parameter int CLASS_X     = 1,
    parameter int CLASS_Y     = 18
) (
    input  logic       video_clk,
    input  logic       rst_n,
    input  vid_pos_t   timing,
    input  bin_img_t   bin_img,
    input  class_vec_t class_vec,
    output vid_sync_t  sync_out,
    output rgb888_t    pixel_out
);

    coord_t     bin_cx;       // x in binary cells
    coord_t     bin_cy;
    coord_t     cls_cx;       // x in class cells
    coord_t     cls_cy;
    logic       in_bin;
    logic       in_cls;
    logic [9:0] bin_idx;      // bit number in bin_img
    logic [3:0] cls_idx;      // bit number in class_vec
    logic       bin_bit;
    logic       cls_bit;
    rgb888_t    pix;

    // ------------------------------------------------------------------------
    // window lookup
    // ------------------------------------------------------------------------
    assign bin_cx = timing.x >> BIN_SHIFT;
    assign bin_cy = timing.y >> BIN_SHIFT;
    assign cls_cx = timing.x >> CLASS_SHIFT;
    assign cls_cy = timing.y >> CLASS_SHIFT;

    assign in_bin = (bin_cx >= BIN_X) && (bin_cx < BIN_X + GRID_SIZE)
                 && (bin_cy >= BIN_Y) && (bin_cy < BIN_Y + GRID_SIZE);
    assign in_cls = (cls_cx >= CLASS_X) && (cls_cx < CLASS_X + NUM_CLASSES)
                 && (cls_cy == CLASS_Y);

    // row-major cell index, only meaningful inside the window
    assign bin_idx = in_bin ? 10'((bin_cy - coord_t'(BIN_Y)) * GRID_SIZE
                                  + (bin_cx - coord_t'(BIN_X))) : '0;
    assign cls_idx = in_cls ? 4'(cls_cx - coord_t'(CLASS_X)) : '0;
    assign bin_bit = bin_img[bin_idx];
    assign cls_bit = class_vec[cls_idx];

    // ------------------------------------------------------------------------
    // priority mux
    // ------------------------------------------------------------------------
    always_comb begin
        if (in_bin) begin
            pix = {3{ {8{bin_bit}} }};              // grey 0 or 255
        end else if (in_cls) begin
            pix = {3{ {8{cls_bit}} }};
        end else begin
            pix.red   = timing.x[7:0];              // gradient background
            pix.green = timing.y[7:0];
            pix.blue  = 8'hff;
        end
    end

    // sync and pixel leave together, one stage
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_out <= '0;
        end else begin
            sync_out <= timing.sync;
        end
    end

    always_ff @(posedge video_clk) begin
        pixel_out <= timing.sync.de ? pix : '0;     // black in blanking
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_mnist_view -f src.f \
    -o tb_mnist_view > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_mnist_view > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$SIM_LOG"; then
    exit 1
fi
exit 0

/* src.f */
cam_pkg.sv
video_pkg.sv
cam_frame_ctrl.sv
cam_sampler.sv
video_timing.sv
overlay_mixer.sv
mnist_view_top.sv
tb_clock_gen.sv
tb_mnist_view.sv

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,   // video clock period
    parameter int RESET_CYCLES = 10   // rst_n low for this many cycles
) (
    output logic video_clk,
    output logic rst_n
);

    initial begin
        video_clk = 1'b0;
        forever #(PERIOD_NS / 2) video_clk = ~video_clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge video_clk);
        @(negedge video_clk);
        rst_n = 1'b1;                        // release away from the rising edge
    end

endmodule

/* tb_mnist_view.sv */
`timescale 1ns/1ps

module tb_mnist_view import cam_pkg::*, video_pkg::*; ();

    // small raster of 80 x 72 counts
    localparam int H_ACT = 64, H_FP = 4, H_SW = 4, H_BP = 8;
    localparam int V_ACT = 64, V_FP = 2, V_SW = 2, V_BP = 4;
    localparam int H_TOT          = H_ACT + H_FP + H_SW + H_BP;
    localparam int V_TOT          = V_ACT + V_FP + V_SW + V_BP;
    localparam int FRAME_CYCLES   = H_TOT * V_TOT;
    localparam int TIMEOUT_CYCLES = 12 * FRAME_CYCLES;   // 12 display frames
    localparam int SAMPLE_SHIFT   = 1;                    // camera step of 2
    localparam int BIN_SHIFT = 1, BIN_X = 2, BIN_Y = 1;
    localparam int CLASS_SHIFT = 2, CLASS_X = 1, CLASS_Y = 15;
    localparam int CAM_SIZE = GRID_SIZE << SAMPLE_SHIFT;  // 56 pixels per side

    logic       video_clk;
    logic       rst_n;
    cam_in_t    cam;
    class_vec_t class_vec;
    vid_sync_t  sync_out;
    rgb888_t    pixel_out;

    logic [31:0] lfsr;
    logic        cell_dark [GRID_SIZE*GRID_SIZE];  // pattern sent to the camera
    logic        exp_img   [GRID_SIZE*GRID_SIZE];  // image the display should show
    int          error_count = 0;
    int          tests_run = 0;
    int          tests_passed = 0;
    int          cycle_count = 0;

    tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(10)) u_clk (.video_clk, .rst_n);

    mnist_view_top #(
        .H_ACTIVE (H_ACT), .H_FRONT (H_FP), .H_SYNC (H_SW), .H_BACK (H_BP),
        .V_ACTIVE (V_ACT), .V_FRONT (V_FP), .V_SYNC (V_SW), .V_BACK (V_BP),
        .SAMPLE_SHIFT (SAMPLE_SHIFT),
        .BIN_SHIFT (BIN_SHIFT), .BIN_X (BIN_X), .BIN_Y (BIN_Y),
        .CLASS_SHIFT (CLASS_SHIFT), .CLASS_X (CLASS_X), .CLASS_Y (CLASS_Y)
    ) uut (.video_clk, .rst_n, .cam, .class_vec, .sync_out, .pixel_out);

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic random_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("CHECK FAILED at time %0t: %s", $time, msg);
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        tests_run++;
        if (error_count == errs_at_start) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed, %0d errors", name, error_count - errs_at_start);
        end
    endtask

    // expected display pixel from window geometry and the tb image model
    function automatic rgb888_t expect_pixel(input int x, input int y);
        int     bcx;
        int     bcy;
        int     ccx;
        int     ccy;
        logic   b;
        bcx = (x >> BIN_SHIFT) - BIN_X;
        bcy = (y >> BIN_SHIFT) - BIN_Y;
        ccx = (x >> CLASS_SHIFT) - CLASS_X;
        ccy = y >> CLASS_SHIFT;
        if (bcx >= 0 && bcx < GRID_SIZE && bcy >= 0 && bcy < GRID_SIZE) begin
            b = exp_img[bcy * GRID_SIZE + bcx];
            return {3{ {8{b}} }};
        end else if (ccx >= 0 && ccx < NUM_CLASSES && ccy == CLASS_Y) begin
            b = class_vec[ccx];
            return {3{ {8{b}} }};
        end
        return {8'(x), 8'(y), 8'hff};                   // gradient background
    endfunction

    task automatic wait_vs_rise();
        do @(negedge video_clk); while (sync_out.vs);
        do @(negedge video_clk); while (!sync_out.vs);
    endtask

    // one full active area with position tracked from de
    task automatic check_frame();
        int      x;
        int      y;
        logic    de_d;
        rgb888_t exp;
        wait_vs_rise();
        x = 0;
        y = 0;
        de_d = 1'b0;
        while (y < V_ACT) begin
            @(negedge video_clk);
            if (sync_out.de) begin
                exp = expect_pixel(x, y);
                if (pixel_out !== exp) begin
                    report_error($sformatf("pixel (%0d,%0d) is %h, expected %h",
                                           x, y, pixel_out, exp));
                end
                x++;
            end else begin
                if (pixel_out !== '0) begin
                    report_error($sformatf("blanking pixel is %h, expected 0", pixel_out));
                end
                if (de_d) begin
                    y++;                                    // line done
                    x = 0;
                end
            end
            de_d = sync_out.de;
        end
    endtask

    // vsync pulse then 56 lines of 56 pixels with each camera cell 2x2 pixels
    task automatic send_cam_frame(input logic end_frame);
        repeat (4) begin
            @(negedge video_clk);
            cam.vsync = 1'b1;
        end
        @(negedge video_clk);
        cam.vsync = 1'b0;
        repeat (4) @(negedge video_clk);                   // frame ctrl enters grab
        for (int r = 0; r < CAM_SIZE; r++) begin
            for (int c = 0; c < CAM_SIZE; c++) begin
                @(negedge video_clk);
                cam.href  = 1'b1;
                cam.valid = 1'b1;
                cam.pixel = cell_dark[(r >> SAMPLE_SHIFT) * GRID_SIZE + (c >> SAMPLE_SHIFT)]
                          ? 16'h0000 : 16'hffff;
            end
            repeat (4) begin
                @(negedge video_clk);
                cam.href  = 1'b0;
                cam.valid = 1'b0;
                cam.pixel = '0;
            end
        end
        if (end_frame) begin
            @(negedge video_clk);
            cam.vsync = 1'b1;                              // frame complete
        end
    endtask

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    task automatic raster_timing();
        int   errs;
        int   cycles;
        int   lines;
        int   run;
        int   gap;          // cycles since de fell
        int   hs_len;
        int   hs_pulses;
        logic de_d;
        logic vs_d;
        logic hs_d;
        errs = error_count;
        wait_vs_rise();
        cycles = 0;
        lines = 0;
        run = 0;
        gap = H_TOT;
        hs_len = 0;
        hs_pulses = 0;
        de_d = 1'b0;
        vs_d = 1'b1;
        hs_d = 1'b0;
        do begin
            @(negedge video_clk);
            cycles++;
            if (sync_out.de) begin
                run++;
            end else if (de_d) begin
                if (run != H_ACT) begin
                    report_error($sformatf("line %0d has %0d de cycles", lines, run));
                end
                lines++;
                run = 0;
                gap = 0;
            end else begin
                gap++;
            end
            if (sync_out.hs) begin
                hs_len++;
                if (!hs_d) begin
                    hs_pulses++;
                    if (gap < H_TOT && gap != H_FP) begin
                        report_error($sformatf("hs starts %0d cycles after de", gap));
                    end
                end
            end else if (hs_d) begin
                if (hs_len != H_SW) begin
                    report_error($sformatf("hs pulse is %0d cycles", hs_len));
                end
                hs_len = 0;
            end
            hs_d = sync_out.hs;
            de_d = sync_out.de;
            if (sync_out.vs && !vs_d) break;              // next frame start
            vs_d = sync_out.vs;
        end while (1);
        if (lines != V_ACT) report_error($sformatf("frame has %0d lines", lines));
        if (hs_pulses != V_TOT) report_error($sformatf("frame has %0d hs pulses", hs_pulses));
        if (cycles != FRAME_CYCLES) report_error($sformatf("vs period is %0d cycles", cycles));
        end_test("raster timing", errs);
    endtask

    task automatic reset_image();
        int errs;
        errs = error_count;
        check_frame();                                     // exp_img still all zero
        end_test("background and reset image", errs);
    endtask

    task automatic binary_capture();
        int errs;
        errs = error_count;
        for (int i = 0; i < GRID_SIZE * GRID_SIZE; i++) cell_dark[i] = random_bit();
        send_cam_frame(1'b1);
        exp_img = cell_dark;
        check_frame();
        end_test("binary capture", errs);
    endtask

    task automatic class_row();
        int         errs;
        class_vec_t v;
        errs = error_count;
        for (int i = 0; i < NUM_CLASSES; i++) v[i] = random_bit();
        @(negedge video_clk);
        class_vec = v;
        check_frame();
        end_test("class row", errs);
    endtask

    task automatic frame_replacement();
        int errs;
        errs = error_count;
        for (int i = 0; i < GRID_SIZE * GRID_SIZE; i++) cell_dark[i] = ~cell_dark[i];
        send_cam_frame(1'b0);                              // vsync held low
        check_frame();                                     // old image still shown
        @(negedge video_clk);
        cam.vsync = 1'b1;
        exp_img = cell_dark;
        check_frame();
        end_test("frame replacement", errs);
    endtask

    // ------------------------------------------------------------------------
    // run control
    // ------------------------------------------------------------------------
    always @(posedge video_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        cam = '0;
        class_vec = '0;
        lfsr = 32'hedba_4db5;
        for (int i = 0; i < GRID_SIZE * GRID_SIZE; i++) begin
            cell_dark[i] = 1'b0;
            exp_img[i] = 1'b0;
        end
        wait (rst_n === 1'b1);
        repeat (2) @(negedge video_clk);
        raster_timing();
        reset_image();
        binary_capture();
        class_row();
        frame_replacement();
        $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* video_pkg.sv */
package video_pkg;

    // ------------------------------------------------------------------------
    // raster coordinates and sync
    // ------------------------------------------------------------------------
    typedef logic [11:0] coord_t;  // enough for 4k counts

    typedef struct packed {
        logic hs;  // horizontal sync, active high
        logic vs;  // vertical sync, active high
        logic de;  // active video
    } vid_sync_t;

    typedef struct packed {
        vid_sync_t sync;
        coord_t    x;  // horizontal count
        coord_t    y;  // vertical count
    } vid_pos_t;

    // ------------------------------------------------------------------------
    // output pixel
    // ------------------------------------------------------------------------
    typedef logic [7:0] chan8_t;

    typedef struct packed {
        chan8_t red;
        chan8_t green;
        chan8_t blue;
    } rgb888_t;

endpackage

/* video_timing.sv */
`timescale 1ns/1ps

module video_timing import video_pkg::*; #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT  = 110,
    parameter int H_SYNC   = 40,
    parameter int H_BACK   = 220,
    parameter int V_ACTIVE = 720,
    parameter int V_FRONT  = 5,
    parameter int V_SYNC   = 5,
    parameter int V_BACK   = 20
) (
    input  logic     video_clk,
    input  logic     rst_n,
    output vid_pos_t timing
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    coord_t    h_cnt;
    coord_t    v_cnt;
    vid_sync_t sync_nxt;    // decoded from current counts

    // ------------------------------------------------------------------------
    // counters
    // ------------------------------------------------------------------------
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == coord_t'(H_TOTAL - 1)) begin
            h_cnt <= '0;                                // end of line
            if (v_cnt == coord_t'(V_TOTAL - 1)) begin
                v_cnt <= '0;                            // end of frame
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // decode and register
    // ------------------------------------------------------------------------
    assign sync_nxt.hs = (h_cnt >= H_ACTIVE + H_FRONT)
                      && (h_cnt <  H_ACTIVE + H_FRONT + H_SYNC);
    assign sync_nxt.vs = (v_cnt >= V_ACTIVE + V_FRONT)
                      && (v_cnt <  V_ACTIVE + V_FRONT + V_SYNC);
    assign sync_nxt.de = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);

    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            timing <= '0;                               // sync low in reset
        end else begin
            timing.sync <= sync_nxt;
            timing.x    <= h_cnt;                       // one cycle behind counters
            timing.y    <= v_cnt;
        end
    end

endmodule
